/* dcache_macros.svh */
// Data cache geometry and replay FIFO sizing
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

`define DCACHE_DWORD_WIDTH 64
`define DCACHE_PTAG_WIDTH 8

// Byte in dword [2:0], word in block [4:3], set index [7:5]
`define DCACHE_OFFSET_WIDTH 8
`define DCACHE_PADDR_WIDTH 16

// Direct mapped
`define DCACHE_SETS 8

// Also the beat count of a fill
`define DCACHE_BLOCK_WORDS 4

`define DCACHE_REPLAY_ELS 8

`endif

/* dcache_pkg.sv */
// Opcode, request packet and memory command types for the data cache
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

   typedef enum logic [0:0]
   {
      e_op_ld = 1'b0
      , e_op_sd = 1'b1
   } dcache_op_e;

   // 73 bits
   typedef struct packed
   {
      dcache_op_e                        opcode;
      logic [`DCACHE_OFFSET_WIDTH-1:0]   page_offset;
      logic [`DCACHE_DWORD_WIDTH-1:0]    data;
   } dcache_pkt_s;

   typedef enum logic [0:0]
   {
      e_mem_rd = 1'b0
      , e_mem_wr = 1'b1
   } mem_op_e;

endpackage

`default_nettype wire

/* dcache_replay_fifo.sv */
// Request FIFO whose issue pointer can roll back to the oldest unretired entry
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_replay_fifo
   #(localparam ptr_width_lp = $clog2(`DCACHE_REPLAY_ELS))
   ( input  logic                            clk_i
   , input  logic                            reset_i

   , input  dcache_pkg::dcache_pkt_s         enq_pkt_i
   , input  logic [`DCACHE_PTAG_WIDTH-1:0]   enq_ptag_i
   , input  logic                            enq_v_i
   , output logic                            enq_ready_o

   , output dcache_pkg::dcache_pkt_s         issue_pkt_o
   , output logic [`DCACHE_PTAG_WIDTH-1:0]   issue_ptag_o
   , output logic                            issue_v_o
   , input  logic                            issue_yumi_i

   , input  logic                            retire_i
   , input  logic                            roll_i
   );

   dcache_pkg::dcache_pkt_s pkt_mem [`DCACHE_REPLAY_ELS];
   logic [`DCACHE_PTAG_WIDTH-1:0] ptag_mem [`DCACHE_REPLAY_ELS];

   // Extra MSB tells full from empty
   logic [ptr_width_lp:0] wptr_r, iptr_r, rptr_r;
   logic [ptr_width_lp:0] wptr_n, rptr_n;
   logic enq, full_n, ready_r;

   assign enq = enq_v_i & ready_r;
   assign wptr_n = wptr_r + {{ptr_width_lp{1'b0}}, enq};
   assign rptr_n = rptr_r + {{ptr_width_lp{1'b0}}, retire_i};
   assign full_n = (wptr_n[ptr_width_lp] != rptr_n[ptr_width_lp])
                   & (wptr_n[ptr_width_lp-1:0] == rptr_n[ptr_width_lp-1:0]);

   assign enq_ready_o = ready_r;
   assign issue_v_o = (iptr_r != wptr_r);
   assign issue_pkt_o = pkt_mem[iptr_r[ptr_width_lp-1:0]];
   assign issue_ptag_o = ptag_mem[iptr_r[ptr_width_lp-1:0]];

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         pkt_mem[wptr_r[ptr_width_lp-1:0]] <= enq_pkt_i;
         ptag_mem[wptr_r[ptr_width_lp-1:0]] <= enq_ptag_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wptr_r <= '0;
         iptr_r <= '0;
         rptr_r <= '0;
         ready_r <= 1'b0;
      end
      else
      begin
         wptr_r <= wptr_n;
         rptr_r <= rptr_n;
         ready_r <= ~full_n;
         // Replay everything not yet retired
         if (roll_i)
            iptr_r <= rptr_r;
         else if (issue_yumi_i)
            iptr_r <= iptr_r + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* dcache_pipe.sv */
// Tag, valid and data arrays with the three-stage lookup, poison and result logic
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_pipe
   #(localparam index_width_lp = $clog2(`DCACHE_SETS)
   , localparam word_width_lp = $clog2(`DCACHE_BLOCK_WORDS)
   )
   ( input  logic                              clk_i
   , input  logic                              reset_i

   , input  dcache_pkg::dcache_pkt_s           issue_pkt_i
   , input  logic [`DCACHE_PTAG_WIDTH-1:0]     issue_ptag_i
   , input  logic                              issue_v_i
   , output logic                              issue_yumi_o
   , output logic                              retire_o
   , output logic                              roll_o

   , output logic                              req_v_o
   , output dcache_pkg::dcache_op_e            req_op_o
   , output logic [`DCACHE_PADDR_WIDTH-1:0]    req_addr_o
   , output logic [`DCACHE_DWORD_WIDTH-1:0]    req_data_o
   , input  logic                              req_yumi_i

   , input  logic                              fill_v_i
   , input  logic [index_width_lp-1:0]         fill_index_i
   , input  logic [word_width_lp-1:0]          fill_word_i
   , input  logic [`DCACHE_DWORD_WIDTH-1:0]    fill_data_i
   , input  logic                              tag_v_i
   , input  logic [index_width_lp-1:0]         tag_index_i
   , input  logic [`DCACHE_PTAG_WIDTH-1:0]     tag_i
   , input  logic                              busy_i

   , output logic [`DCACHE_DWORD_WIDTH-1:0]    data_o
   , output logic                              v_o
   );

   localparam byte_width_lp = $clog2(`DCACHE_DWORD_WIDTH/8);
   localparam line_width_lp = index_width_lp + word_width_lp;

   logic [`DCACHE_PTAG_WIDTH-1:0] tag_mem [`DCACHE_SETS];
   logic [`DCACHE_SETS-1:0] valid_r;
   // Addressed by {set, word}
   logic [`DCACHE_DWORD_WIDTH-1:0] data_mem [`DCACHE_SETS*`DCACHE_BLOCK_WORDS];

   logic [line_width_lp-1:0] issue_line, line_tv;
   logic [index_width_lp-1:0] issue_index;

   // Verify stage
   logic v_tv_r, tag_valid_tv_r;
   dcache_pkg::dcache_pkt_s pkt_tv_r;
   logic [`DCACHE_PTAG_WIDTH-1:0] ptag_tv_r, tag_tv_r;
   logic [`DCACHE_DWORD_WIDTH-1:0] data_tv_r;
   logic store_tv, hit_tv, ok_tv;

   // Result stage
   logic v_rs_r, ok_rs_r, store_rs_r;
   logic [`DCACHE_DWORD_WIDTH-1:0] data_rs_r;

   assign issue_line = issue_pkt_i.page_offset[byte_width_lp +: line_width_lp];
   assign issue_index = issue_line[word_width_lp +: index_width_lp];
   assign line_tv = pkt_tv_r.page_offset[byte_width_lp +: line_width_lp];

   // Hold off after a store so its array write lands before the next read
   assign issue_yumi_o = issue_v_i & ~busy_i & ~roll_o & ~(v_tv_r & store_tv);

   assign store_tv = (pkt_tv_r.opcode == dcache_pkg::e_op_sd);
   assign hit_tv = tag_valid_tv_r & (tag_tv_r == ptag_tv_r);
   assign ok_tv = store_tv ? req_yumi_i : hit_tv;

   // A flushed item must not reach the engine
   assign req_v_o = v_tv_r & (store_tv | ~hit_tv) & ~roll_o;
   assign req_op_o = pkt_tv_r.opcode;
   assign req_addr_o = {ptag_tv_r, pkt_tv_r.page_offset};
   assign req_data_o = pkt_tv_r.data;

   assign v_o = v_rs_r & ok_rs_r;
   assign roll_o = v_rs_r & ~ok_rs_r;
   assign retire_o = v_o;
   assign data_o = store_rs_r ? '0 : data_rs_r;

   always_ff @(posedge clk_i)
   begin
      if (fill_v_i)
         data_mem[{fill_index_i, fill_word_i}] <= fill_data_i;
      else if (v_tv_r & store_tv & hit_tv & req_yumi_i)
         data_mem[line_tv] <= pkt_tv_r.data;
      if (tag_v_i)
         tag_mem[tag_index_i] <= tag_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         valid_r <= '0;
      else if (tag_v_i)
         valid_r[tag_index_i] <= 1'b1;
   end

   always_ff @(posedge clk_i)
   begin
      pkt_tv_r <= issue_pkt_i;
      ptag_tv_r <= issue_ptag_i;
      tag_tv_r <= tag_mem[issue_index];
      tag_valid_tv_r <= valid_r[issue_index];
      data_tv_r <= data_mem[issue_line];
      ok_rs_r <= ok_tv;
      store_rs_r <= store_tv;
      data_rs_r <= data_tv_r;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         v_tv_r <= 1'b0;
         v_rs_r <= 1'b0;
      end
      else
      begin
         v_tv_r <= issue_yumi_o;
         // Poison flushes the younger item
         v_rs_r <= v_tv_r & ~roll_o;
      end
   end

endmodule

`default_nettype wire

/* dcache_uce.sv */
// Uncached engine serving block fills and write-through stores to memory
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_uce
   #(localparam index_width_lp = $clog2(`DCACHE_SETS)
   , localparam word_width_lp = $clog2(`DCACHE_BLOCK_WORDS)
   )
   ( input  logic                              clk_i
   , input  logic                              reset_i

   , input  logic                              req_v_i
   , input  dcache_pkg::dcache_op_e            req_op_i
   , input  logic [`DCACHE_PADDR_WIDTH-1:0]    req_addr_i
   , input  logic [`DCACHE_DWORD_WIDTH-1:0]    req_data_i
   , output logic                              req_yumi_o

   , output logic                              fill_v_o
   , output logic [index_width_lp-1:0]         fill_index_o
   , output logic [word_width_lp-1:0]          fill_word_o
   , output logic [`DCACHE_DWORD_WIDTH-1:0]    fill_data_o
   , output logic                              tag_v_o
   , output logic [index_width_lp-1:0]         tag_index_o
   , output logic [`DCACHE_PTAG_WIDTH-1:0]     tag_o
   , output logic                              busy_o

   , output dcache_pkg::mem_op_e               mem_cmd_op_o
   , output logic [`DCACHE_PADDR_WIDTH-1:0]    mem_cmd_addr_o
   , output logic [`DCACHE_DWORD_WIDTH-1:0]    mem_cmd_data_o
   , output logic                              mem_cmd_v_o
   , output logic                              mem_cmd_last_o
   , input  logic                              mem_cmd_ready_and_i

   , input  logic [`DCACHE_DWORD_WIDTH-1:0]    mem_resp_data_i
   , input  logic                              mem_resp_v_i
   , input  logic                              mem_resp_last_i
   , output logic                              mem_resp_ready_and_o
   );

   localparam block_lsb_lp = $clog2(`DCACHE_DWORD_WIDTH/8) + word_width_lp;

   typedef enum logic [1:0] {e_idle, e_send_wr, e_send_rd, e_recv} state_e;

   state_e state_r, state_n;
   logic [`DCACHE_PADDR_WIDTH-1:0] addr_r;
   logic [`DCACHE_DWORD_WIDTH-1:0] data_r;
   logic [word_width_lp-1:0] beat_r;

   assign req_yumi_o = req_v_i & (state_r == e_idle);
   assign busy_o = (state_r != e_idle);

   // Single-beat commands; reads go out block aligned
   assign mem_cmd_v_o = (state_r == e_send_wr) | (state_r == e_send_rd);
   assign mem_cmd_op_o = (state_r == e_send_wr) ? dcache_pkg::e_mem_wr : dcache_pkg::e_mem_rd;
   assign mem_cmd_addr_o = (state_r == e_send_wr)
                           ? addr_r
                           : {addr_r[`DCACHE_PADDR_WIDTH-1:block_lsb_lp], {block_lsb_lp{1'b0}}};
   assign mem_cmd_data_o = data_r;
   assign mem_cmd_last_o = 1'b1;
   assign mem_resp_ready_and_o = (state_r == e_recv);

   assign fill_v_o = (state_r == e_recv) & mem_resp_v_i;
   assign fill_index_o = addr_r[block_lsb_lp +: index_width_lp];
   assign fill_word_o = beat_r;
   assign fill_data_o = mem_resp_data_i;

   // Tag goes valid with the last beat
   assign tag_v_o = fill_v_o & mem_resp_last_i;
   assign tag_index_o = addr_r[block_lsb_lp +: index_width_lp];
   assign tag_o = addr_r[`DCACHE_PADDR_WIDTH-1 -: `DCACHE_PTAG_WIDTH];

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_idle:
            if (req_yumi_o)
               state_n = (req_op_i == dcache_pkg::e_op_sd) ? e_send_wr : e_send_rd;
         e_send_wr:
            if (mem_cmd_ready_and_i)
               state_n = e_idle;
         e_send_rd:
            if (mem_cmd_ready_and_i)
               state_n = e_recv;
         e_recv:
            if (tag_v_o)
               state_n = e_idle;
         default:
            state_n = e_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         state_r <= e_idle;
      else
         state_r <= state_n;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i | (state_r == e_send_rd))
         beat_r <= '0;
      else if (fill_v_o)
         beat_r <= beat_r + 1'b1;
   end

   always_ff @(posedge clk_i)
   begin
      if (req_yumi_o)
      begin
         addr_r <= req_addr_i;
         data_r <= req_data_i;
      end
   end

endmodule

`default_nettype wire

/* dcache_top.sv */
// Data cache top level joining the replay FIFO, lookup pipeline and uncached engine
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top
   ( input  logic                              clk_i
   , input  logic                              reset_i

   , input  dcache_pkg::dcache_pkt_s           pkt_i
   , input  logic [`DCACHE_PTAG_WIDTH-1:0]     ptag_i
   , input  logic                              v_i
   , output logic                              ready_o

   , output logic [`DCACHE_DWORD_WIDTH-1:0]    data_o
   , output logic                              v_o

   , output dcache_pkg::mem_op_e               mem_cmd_op_o
   , output logic [`DCACHE_PADDR_WIDTH-1:0]    mem_cmd_addr_o
   , output logic [`DCACHE_DWORD_WIDTH-1:0]    mem_cmd_data_o
   , output logic                              mem_cmd_v_o
   , output logic                              mem_cmd_last_o
   , input  logic                              mem_cmd_ready_and_i

   , input  logic [`DCACHE_DWORD_WIDTH-1:0]    mem_resp_data_i
   , input  logic                              mem_resp_v_i
   , input  logic                              mem_resp_last_i
   , output logic                              mem_resp_ready_and_o
   );

   localparam index_width_lp = $clog2(`DCACHE_SETS);
   localparam word_width_lp = $clog2(`DCACHE_BLOCK_WORDS);

   // FIFO and pipe
   dcache_pkg::dcache_pkt_s issue_pkt;
   logic [`DCACHE_PTAG_WIDTH-1:0] issue_ptag;
   logic issue_v, issue_yumi, retire, roll;

   // Pipe and engine
   logic req_v, req_yumi;
   dcache_pkg::dcache_op_e req_op;
   logic [`DCACHE_PADDR_WIDTH-1:0] req_addr;
   logic [`DCACHE_DWORD_WIDTH-1:0] req_data;

   logic fill_v, tag_v, busy;
   logic [index_width_lp-1:0] fill_index, tag_index;
   logic [word_width_lp-1:0] fill_word;
   logic [`DCACHE_DWORD_WIDTH-1:0] fill_data;
   logic [`DCACHE_PTAG_WIDTH-1:0] tag;

   dcache_replay_fifo u_replay_fifo
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.enq_pkt_i(pkt_i)
      ,.enq_ptag_i(ptag_i)
      ,.enq_v_i(v_i)
      ,.enq_ready_o(ready_o)
      ,.issue_pkt_o(issue_pkt)
      ,.issue_ptag_o(issue_ptag)
      ,.issue_v_o(issue_v)
      ,.issue_yumi_i(issue_yumi)
      ,.retire_i(retire)
      ,.roll_i(roll)
      );

   dcache_pipe u_pipe
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.issue_pkt_i(issue_pkt)
      ,.issue_ptag_i(issue_ptag)
      ,.issue_v_i(issue_v)
      ,.issue_yumi_o(issue_yumi)
      ,.retire_o(retire)
      ,.roll_o(roll)
      ,.req_v_o(req_v)
      ,.req_op_o(req_op)
      ,.req_addr_o(req_addr)
      ,.req_data_o(req_data)
      ,.req_yumi_i(req_yumi)
      ,.fill_v_i(fill_v)
      ,.fill_index_i(fill_index)
      ,.fill_word_i(fill_word)
      ,.fill_data_i(fill_data)
      ,.tag_v_i(tag_v)
      ,.tag_index_i(tag_index)
      ,.tag_i(tag)
      ,.busy_i(busy)
      ,.data_o(data_o)
      ,.v_o(v_o)
      );

   dcache_uce u_uce
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.req_v_i(req_v)
      ,.req_op_i(req_op)
      ,.req_addr_i(req_addr)
      ,.req_data_i(req_data)
      ,.req_yumi_o(req_yumi)
      ,.fill_v_o(fill_v)
      ,.fill_index_o(fill_index)
      ,.fill_word_o(fill_word)
      ,.fill_data_o(fill_data)
      ,.tag_v_o(tag_v)
      ,.tag_index_o(tag_index)
      ,.tag_o(tag)
      ,.busy_o(busy)
      ,.mem_cmd_op_o(mem_cmd_op_o)
      ,.mem_cmd_addr_o(mem_cmd_addr_o)
      ,.mem_cmd_data_o(mem_cmd_data_o)
      ,.mem_cmd_v_o(mem_cmd_v_o)
      ,.mem_cmd_last_o(mem_cmd_last_o)
      ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
      ,.mem_resp_data_i(mem_resp_data_i)
      ,.mem_resp_v_i(mem_resp_v_i)
      ,.mem_resp_last_i(mem_resp_last_i)
      ,.mem_resp_ready_and_o(mem_resp_ready_and_o)
      );

endmodule

`default_nettype wire

/* tb_dcache_checker.sv */
// Data cache checker with a reference memory, expected result and write queues
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache_checker
   ( input  logic                              clk_i
   , input  logic                              reset_i
   , input  dcache_pkg::dcache_pkt_s           req_pkt_i
   , input  logic [`DCACHE_PTAG_WIDTH-1:0]     req_ptag_i
   , input  logic                              req_v_i
   , input  logic                              req_ready_i
   , input  logic [`DCACHE_DWORD_WIDTH-1:0]    resp_data_i
   , input  logic                              resp_v_i
   , input  dcache_pkg::mem_op_e               cmd_op_i
   , input  logic [`DCACHE_PADDR_WIDTH-1:0]    cmd_addr_i
   , input  logic [`DCACHE_DWORD_WIDTH-1:0]    cmd_data_i
   , input  logic                              cmd_v_i
   , input  logic                              cmd_last_i
   , input  logic                              cmd_ready_i
   , input  logic                              mem_resp_v_i
   , input  logic                              mem_resp_last_i
   , input  logic                              mem_resp_ready_i
   , output int                                pending_o
   , output int                                value_errors_o
   , output int                                protocol_errors_o
   );

   logic [63:0] ref_mem [logic [12:0]];
   logic [63:0] result_q [$];
   // {address, data} of each store in store order
   logic [79:0] write_q [$];
   logic after_reset = 1'b0;
   // Block read between command and last beat
   logic read_open = 1'b0;
   int value_errors = 0;
   int protocol_errors = 0;
   int pending = 0;

   assign pending_o = pending;
   assign value_errors_o = value_errors;
   assign protocol_errors_o = protocol_errors;

   function automatic logic [63:0] initial_content(input logic [12:0] a);
      return {a, 3'b101, ~a, 3'b011, a ^ 13'h0a5c, 3'b110, 16'hc0de};
   endfunction

   always @(posedge clk_i)
   begin
      logic [12:0] dword;
      logic [63:0] expected;
      logic [79:0] write;
      if (reset_i)
      begin
         after_reset = 1'b1;
         read_open = 1'b0;
      end
      else
      begin
         if (after_reset && (resp_v_i || cmd_v_i || req_ready_i))
         begin
            $display("Valid or ready output high in the first cycle after reset at %0t",
                     $time);
            protocol_errors++;
         end
         after_reset = 1'b0;
         if (mem_resp_ready_i && !read_open)
         begin
            $display("Memory response ready while no read was open at %0t", $time);
            protocol_errors++;
         end
         if (mem_resp_v_i && mem_resp_ready_i && mem_resp_last_i)
            read_open = 1'b0;
         if (req_v_i && req_ready_i)
         begin
            dword = {req_ptag_i, req_pkt_i.page_offset[7:3]};
            if (req_pkt_i.opcode == dcache_pkg::e_op_sd)
            begin
               result_q.push_back('0);
               ref_mem[dword] = req_pkt_i.data;
               write_q.push_back({req_ptag_i, req_pkt_i.page_offset, req_pkt_i.data});
            end
            else
               result_q.push_back(ref_mem.exists(dword)
                                  ? ref_mem[dword] : initial_content(dword));
         end
         if (resp_v_i)
         begin
            if (result_q.size() == 0)
            begin
               $display("Result came out with no request outstanding at %0t", $time);
               protocol_errors++;
            end
            else
            begin
               expected = result_q.pop_front();
               if (resp_data_i !== expected)
               begin
                  $display("FAILED %0t: result %h, expected %h", $time, resp_data_i, expected);
                  value_errors++;
               end
            end
         end
         if (cmd_v_i && cmd_ready_i)
         begin
            if (cmd_last_i !== 1'b1)
            begin
               $display("Memory command without last set at %0t", $time);
               protocol_errors++;
            end
            if (cmd_op_i == dcache_pkg::e_mem_rd)
               read_open = 1'b1;
            if (cmd_op_i == dcache_pkg::e_mem_rd && cmd_addr_i[4:0] != 5'd0)
            begin
               $display("FAILED %0t: read address %h not block aligned", $time, cmd_addr_i);
               value_errors++;
            end
            else if (cmd_op_i == dcache_pkg::e_mem_wr && write_q.size() == 0)
            begin
               $display("Write command with no store outstanding at %0t", $time);
               protocol_errors++;
            end
            else if (cmd_op_i == dcache_pkg::e_mem_wr)
            begin
               write = write_q.pop_front();
               if ({cmd_addr_i, cmd_data_i} !== write)
               begin
                  $display("FAILED %0t: write %h/%h, expected %h/%h", $time,
                           cmd_addr_i, cmd_data_i, write[79:64], write[63:0]);
                  value_errors++;
               end
            end
         end
      end
      pending = result_q.size() + write_q.size();
   end

endmodule

`default_nettype wire

/* tb_dcache.sv */
// Data cache testbench driving random loads and stores against a stalling memory model
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache;

   localparam int num_requests = 400;
   localparam int reset_cycles = 10;
   localparam int timeout_cycles = num_requests * 40 + reset_cycles;
   localparam logic [31:0] seed = 32'hf099_a6ae;

   logic clk, reset;
   dcache_pkg::dcache_pkt_s pkt;
   logic [`DCACHE_PTAG_WIDTH-1:0] ptag;
   logic req_v, req_ready, resp_v;
   logic [`DCACHE_DWORD_WIDTH-1:0] resp_data, cmd_data, mem_data;
   dcache_pkg::mem_op_e cmd_op;
   logic [`DCACHE_PADDR_WIDTH-1:0] cmd_addr;
   logic cmd_v, cmd_last, cmd_ready;
   logic mem_v, mem_last, mem_ready;
   int value_errors, protocol_errors, pending;

   // Dword addressed memory model whose untouched words follow the fill pattern
   logic [63:0] mem [logic [12:0]];
   logic rd_pending;
   logic [12:0] rd_base;
   logic [1:0] rd_beat;
   logic [31:0] req_rand, mem_rand;
   int cycle_count;

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [63:0] memory_pattern(input logic [12:0] a);
      return {a, 3'b101, ~a, 3'b011, a ^ 13'h0a5c, 3'b110, 16'hc0de};
   endfunction

   function automatic logic [63:0] mem_read(input logic [12:0] a);
      return mem.exists(a) ? mem[a] : memory_pattern(a);
   endfunction

   task automatic print_counts();
      $display("Requests %0d, value errors %0d, protocol errors %0d, outstanding %0d",
               num_requests, value_errors, protocol_errors, pending);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   dcache_top u_dut
      (.clk_i(clk), .reset_i(reset)
      ,.pkt_i(pkt), .ptag_i(ptag), .v_i(req_v), .ready_o(req_ready)
      ,.data_o(resp_data), .v_o(resp_v)
      ,.mem_cmd_op_o(cmd_op), .mem_cmd_addr_o(cmd_addr), .mem_cmd_data_o(cmd_data)
      ,.mem_cmd_v_o(cmd_v), .mem_cmd_last_o(cmd_last), .mem_cmd_ready_and_i(cmd_ready)
      ,.mem_resp_data_i(mem_data), .mem_resp_v_i(mem_v), .mem_resp_last_i(mem_last)
      ,.mem_resp_ready_and_o(mem_ready)
      );

   tb_dcache_checker u_checker
      (.clk_i(clk), .reset_i(reset)
      ,.req_pkt_i(pkt), .req_ptag_i(ptag), .req_v_i(req_v), .req_ready_i(req_ready)
      ,.resp_data_i(resp_data), .resp_v_i(resp_v)
      ,.cmd_op_i(cmd_op), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data)
      ,.cmd_v_i(cmd_v), .cmd_last_i(cmd_last), .cmd_ready_i(cmd_ready)
      ,.mem_resp_v_i(mem_v), .mem_resp_last_i(mem_last), .mem_resp_ready_i(mem_ready)
      ,.pending_o(pending), .value_errors_o(value_errors), .protocol_errors_o(protocol_errors)
      );

   // Four ptags share each set so blocks get evicted
   initial
   begin
      reset = 1'b1;
      pkt = '0;
      ptag = '0;
      req_v = 1'b0;
      req_rand = seed;
      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < num_requests; i++)
      begin
         req_rand = lcg_step(req_rand);
         repeat (req_rand[31:30]) @(negedge clk);
         req_rand = lcg_step(req_rand);
         pkt.opcode = req_rand[31] ? dcache_pkg::e_op_sd : dcache_pkg::e_op_ld;
         pkt.page_offset = {req_rand[30:26], 3'b000};
         ptag = {req_rand[25:24], 6'h2a};
         req_rand = lcg_step(req_rand);
         pkt.data[63:32] = req_rand;
         req_rand = lcg_step(req_rand);
         pkt.data[31:0] = req_rand;
         req_v = 1'b1;
         // ready_o is a register, stable here until the next rising edge
         while (!req_ready)
            @(negedge clk);
         @(negedge clk);
         req_v = 1'b0;
      end
      while (pending != 0)
         @(negedge clk);
      // Drain so stray results still get caught
      repeat (20) @(negedge clk);
      print_counts();
      if (value_errors == 0 && protocol_errors == 0 && pending == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // Sample accepted memory commands and response beats
   initial
   begin
      rd_pending = 1'b0;
      rd_base = '0;
      rd_beat = '0;
      forever
      begin
         @(posedge clk);
         if (!reset && cmd_v && cmd_ready)
         begin
            if (cmd_op == dcache_pkg::e_mem_wr)
               mem[cmd_addr[15:3]] = cmd_data;
            else
            begin
               rd_pending = 1'b1;
               rd_base = cmd_addr[15:3];
               rd_beat = '0;
            end
         end
         if (mem_v && mem_ready)
         begin
            if (mem_last)
               rd_pending = 1'b0;
            rd_beat = rd_beat + 2'd1;
         end
      end
   end

   // Memory side driving with random stalls
   initial
   begin
      cmd_ready = 1'b0;
      mem_v = 1'b0;
      mem_last = 1'b0;
      mem_data = '0;
      mem_rand = seed ^ 32'h1357_9bdf;
      forever
      begin
         @(negedge clk);
         mem_rand = lcg_step(mem_rand);
         cmd_ready = (mem_rand[31:30] != 2'b00);
         mem_v = rd_pending & (mem_rand[29:28] != 2'b00);
         mem_data = mem_read({rd_base[12:2], rd_beat});
         mem_last = (rd_beat == 2'd3);
      end
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      print_counts();
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
dcache_pkg.sv
dcache_replay_fifo.sv
dcache_pipe.sv
dcache_uce.sv
dcache_top.sv
tb_dcache_checker.sv
tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_dcache -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output="$(./obj_dir/Vtb_dcache)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx 'All tests passed!'; then
   exit 0
fi
exit 1
